//--- hdl/video_config.svh
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// horizontal line segments, in clocks.
`define VID_H_ACTIVE 8
`define VID_H_FP 4
`define VID_H_SYNC 2
`define VID_H_BP 4

// vertical frame segments, in lines.
`define VID_V_ACTIVE 4
`define VID_V_FP 1
`define VID_V_SYNC 1
`define VID_V_BP 1

// pixels per camera buffer, power of two.
`define VID_FIFO_DEPTH 16

// frames per buffer tick after reset.
`define VID_TICK_DIV_RST 2

`endif

//--- hdl/video_pkg.sv
`default_nettype none

package video_pkg;

    // rgb565, red on top.
    typedef logic [15:0] pixel565_t;

    typedef logic [11:0] hcount_t;
    typedef logic [11:0] vcount_t;

    // code 3 is shown as camera 1.
    typedef enum logic [1:0] {
        VIEW_CAM1  = 2'd0,
        VIEW_CAM2  = 2'd1,
        VIEW_SPLIT = 2'd2
    } view_mode_t;

    typedef enum logic [1:0] {
        REG_MODE     = 2'd0,
        REG_TICK_DIV = 2'd1,
        REG_ERR_CLR  = 2'd2
    } reg_addr_t;

    typedef logic [15:0] reg_data_t;

    typedef struct packed {
        logic      valid;
        pixel565_t pixel;
    } cam_beat_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        reg_data_t data;
    } cfg_write_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } vid_timing_t;

endpackage : video_pkg

`default_nettype wire

//--- hdl/line_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "video_config.svh"

module line_fifo
    import video_pkg::*;
#(
    parameter int DEPTH = `VID_FIFO_DEPTH
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      push,
    input  pixel565_t push_data,
    input  logic      pop,
    output pixel565_t pop_data,
    output logic      full,
    output logic      empty
);

    localparam int AW = $clog2(DEPTH);

    pixel565_t      mem [DEPTH];
    logic [AW:0]    wr_ptr;
    logic [AW:0]    rd_ptr;
    logic           do_push;
    logic           do_pop;

    // extra pointer bit tells full from empty.
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // head entry, no read latency.
    assign pop_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule : line_fifo

`default_nettype wire

//--- hdl/pixel_combine.sv
`timescale 1ns/1ns
`default_nettype none

`include "video_config.svh"

module pixel_combine
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  cam_beat_t  cam1,
    input  cam_beat_t  cam2,
    input  logic       read_en,
    input  hcount_t    h_cnt,
    input  view_mode_t mode,
    input  logic       err_clear,
    output pixel565_t  pixel,
    output logic       error
);

    localparam hcount_t SPLIT_X = hcount_t'(`VID_H_ACTIVE / 2);

    pixel565_t pix_1;
    pixel565_t pix_2;
    pixel565_t pix_sel;
    logic      full_1;
    logic      full_2;
    logic      empty_1;
    logic      empty_2;
    logic      pop_both;
    logic      overflow;
    logic      underflow;

    // pop only when both have data so the streams stay paired.
    assign underflow = read_en && (empty_1 || empty_2);
    assign pop_both  = read_en && !empty_1 && !empty_2;
    assign overflow  = (cam1.valid && full_1) || (cam2.valid && full_2);

    line_fifo u_fifo_1 (
        .clk      (clk                     ),
        .rst      (rst                     ),
        .push     (cam1.valid && !full_1   ),
        .push_data(cam1.pixel              ),
        .pop      (pop_both                ),
        .pop_data (pix_1                   ),
        .full     (full_1                  ),
        .empty    (empty_1                 )
    );

    line_fifo u_fifo_2 (
        .clk      (clk                     ),
        .rst      (rst                     ),
        .push     (cam2.valid && !full_2   ),
        .push_data(cam2.pixel              ),
        .pop      (pop_both                ),
        .pop_data (pix_2                   ),
        .full     (full_2                  ),
        .empty    (empty_2                 )
    );

    always_comb begin
        case (mode)
            VIEW_CAM2:  pix_sel = pix_2;
            VIEW_SPLIT: pix_sel = (h_cnt < SPLIT_X) ? pix_1 : pix_2;
            default:    pix_sel = pix_1;
        endcase
    end

    // blank outside the active area and on underflow.
    always_ff @(posedge clk) begin
        if (rst) begin
            pixel <= '0;
        end else begin
            pixel <= pop_both ? pix_sel : '0;
        end
    end

    // a new fault in the clearing cycle still sticks.
    always_ff @(posedge clk) begin
        if (rst) begin
            error <= 1'b0;
        end else begin
            error <= (error && !err_clear) || overflow || underflow;
        end
    end

endmodule : pixel_combine

`default_nettype wire

//--- hdl/sync_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "video_config.svh"

module sync_gen
    import video_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    output vid_timing_t timing,
    output logic        read_en,
    output hcount_t     h_cnt,
    output logic        frame_start
);

    localparam hcount_t H_ACTIVE = hcount_t'(`VID_H_ACTIVE);
    localparam hcount_t H_SYNC_BEGIN = hcount_t'(`VID_H_ACTIVE + `VID_H_FP);
    localparam hcount_t H_SYNC_END = hcount_t'(`VID_H_ACTIVE + `VID_H_FP + `VID_H_SYNC);
    localparam hcount_t H_LAST =
        hcount_t'(`VID_H_ACTIVE + `VID_H_FP + `VID_H_SYNC + `VID_H_BP - 1);

    localparam vcount_t V_ACTIVE = vcount_t'(`VID_V_ACTIVE);
    localparam vcount_t V_SYNC_BEGIN = vcount_t'(`VID_V_ACTIVE + `VID_V_FP);
    localparam vcount_t V_SYNC_END = vcount_t'(`VID_V_ACTIVE + `VID_V_FP + `VID_V_SYNC);
    localparam vcount_t V_LAST =
        vcount_t'(`VID_V_ACTIVE + `VID_V_FP + `VID_V_SYNC + `VID_V_BP - 1);

    vcount_t v_cnt;
    logic    h_wrap;
    logic    hsync_next;
    logic    vsync_next;

    assign h_wrap = (h_cnt == H_LAST);

    // line order is active, front porch, sync, back porch.
    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt <= '0;
        end else if (h_wrap) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v_cnt <= '0;
        end else if (h_wrap) begin
            if (v_cnt == V_LAST) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    assign read_en     = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
    assign frame_start = (h_cnt == '0) && (v_cnt == '0);

    assign hsync_next = (h_cnt >= H_SYNC_BEGIN) && (h_cnt < H_SYNC_END);
    assign vsync_next = (v_cnt >= V_SYNC_BEGIN) && (v_cnt < V_SYNC_END);

    // one stage behind read_en, in step with the registered pixel.
    always_ff @(posedge clk) begin
        if (rst) begin
            timing <= '0;
        end else begin
            timing.hsync <= hsync_next;
            timing.vsync <= vsync_next;
            timing.de    <= read_en;
        end
    end

endmodule : sync_gen

`default_nettype wire

//--- hdl/video_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "video_config.svh"

module video_regs
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  cfg_write_t cfg,
    input  logic       frame_start,
    output view_mode_t mode,
    output logic       err_clear,
    output logic       buf_tick
);

    reg_data_t tick_div;
    reg_data_t div_eff;
    reg_data_t frame_cnt;
    logic      div_write;

    assign div_write = cfg.we && (cfg.addr == REG_TICK_DIV);

    // zero divider behaves as one.
    assign div_eff = (tick_div == '0) ? reg_data_t'(1) : tick_div;

    always_ff @(posedge clk) begin
        if (rst) begin
            mode      <= VIEW_CAM1;
            tick_div  <= reg_data_t'(`VID_TICK_DIV_RST);
            err_clear <= 1'b0;
        end else begin
            err_clear <= 1'b0;
            if (cfg.we) begin
                case (cfg.addr)
                    REG_MODE:     mode <= view_mode_t'(cfg.data[1:0]);
                    REG_TICK_DIV: tick_div <= cfg.data;
                    REG_ERR_CLR:  err_clear <= 1'b1;
                    default:      ;
                endcase
            end
        end
    end

    // frame counter, restarted by a divider write.
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_cnt <= '0;
            buf_tick  <= 1'b0;
        end else begin
            buf_tick <= 1'b0;
            if (div_write) begin
                frame_cnt <= '0;
            end else if (frame_start) begin
                if (frame_cnt + 1'b1 >= div_eff) begin
                    frame_cnt <= '0;
                    buf_tick  <= 1'b1;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

endmodule : video_regs

`default_nettype wire

//--- hdl/video_top.sv
`timescale 1ns/1ns
`default_nettype none

module video_top
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  cam_beat_t  cam1,
    input  cam_beat_t  cam2,
    input  cfg_write_t cfg,
    output logic       hdmi_hsync,
    output logic       hdmi_vsync,
    output logic       hdmi_de,
    output logic [7:0] hdmi_r,
    output logic [7:0] hdmi_g,
    output logic [7:0] hdmi_b,
    output logic       buf_tick,
    output logic       comb_err
);

    view_mode_t  mode;
    logic        err_clear;
    logic        frame_start;
    logic        read_en;
    hcount_t     h_cnt;
    vid_timing_t timing;
    pixel565_t   comb_pix;

    video_regs u_video_regs (
        .clk        (clk        ),
        .rst        (rst        ),
        .cfg        (cfg        ),
        .frame_start(frame_start),
        .mode       (mode       ),
        .err_clear  (err_clear  ),
        .buf_tick   (buf_tick   )
    );

    sync_gen u_sync_gen (
        .clk        (clk        ),
        .rst        (rst        ),
        .timing     (timing     ),
        .read_en    (read_en    ),
        .h_cnt      (h_cnt      ),
        .frame_start(frame_start)
    );

    pixel_combine u_pixel_combine (
        .clk      (clk      ),
        .rst      (rst      ),
        .cam1     (cam1     ),
        .cam2     (cam2     ),
        .read_en  (read_en  ),
        .h_cnt    (h_cnt    ),
        .mode     (mode     ),
        .err_clear(err_clear),
        .pixel    (comb_pix ),
        .error    (comb_err )
    );

    assign hdmi_hsync = timing.hsync;
    assign hdmi_vsync = timing.vsync;
    assign hdmi_de    = timing.de;

    // 565 to 888 by zero fill.
    assign hdmi_r = {comb_pix[15:11], 3'b000};
    assign hdmi_g = {comb_pix[10:5], 2'b00};
    assign hdmi_b = {comb_pix[4:0], 3'b000};

endmodule : video_top

`default_nettype wire

//--- testbench/tb_video_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "video_config.svh"

module tb_video_top
    import video_pkg::*;
();

    localparam int LINE_TOTAL = `VID_H_ACTIVE + `VID_H_FP + `VID_H_SYNC + `VID_H_BP;
    localparam int NUM_ROWS = 5;
    localparam int FRAMES_PER_ROW = 3;
    localparam int TIMEOUT = 1000;

    // starts low so time zero brings no clock edge.
    logic clk = 1'b0;
    logic rst;
    cam_beat_t cam1;
    cam_beat_t cam2;
    cfg_write_t cfg;
    logic hdmi_hsync;
    logic hdmi_vsync;
    logic hdmi_de;
    logic [7:0] hdmi_r;
    logic [7:0] hdmi_g;
    logic [7:0] hdmi_b;
    logic buf_tick;
    logic comb_err;

    // stimulus table with one row per test.
    logic [1:0] tbl_mode [NUM_ROWS];
    reg_data_t tbl_div [NUM_ROWS];
    pixel565_t tbl_base1 [NUM_ROWS];
    pixel565_t tbl_base2 [NUM_ROWS];
    logic tbl_starve [NUM_ROWS];

    logic [31:0] lcg_state;
    logic [1:0] cur_mode;
    reg_data_t cur_div;
    pixel565_t cur_base1;
    pixel565_t cur_base2;
    int blank_line;
    logic checking;
    logic tick_armed;
    int tick_ref;
    int errors;
    int pixels_checked;
    int ticks_checked;
    int x;
    int y;
    int hs_run;
    int vs_run;
    int vs_rises;
    int tick_cnt;
    logic de_prev;
    logic vs_prev;
    pixel565_t exp_pix;

    video_top dut (
        .clk       (clk       ),
        .rst       (rst       ),
        .cam1      (cam1      ),
        .cam2      (cam2      ),
        .cfg       (cfg       ),
        .hdmi_hsync(hdmi_hsync),
        .hdmi_vsync(hdmi_vsync),
        .hdmi_de   (hdmi_de   ),
        .hdmi_r    (hdmi_r    ),
        .hdmi_g    (hdmi_g    ),
        .hdmi_b    (hdmi_b    ),
        .buf_tick  (buf_tick  ),
        .comb_err  (comb_err  )
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic pixel565_t cam_pixel(input pixel565_t base, input int row, input int col);
        return pixel565_t'(base + row * 16 + col);
    endfunction

    // code 3 falls back to camera 1.
    function automatic pixel565_t expected_pixel(input int col, input int row);
        pixel565_t p1;
        pixel565_t p2;
        p1 = cam_pixel(cur_base1, row, col);
        p2 = cam_pixel(cur_base2, row, col);
        if (cur_mode == 2'd1) begin
            return p2;
        end else if (cur_mode == 2'd2) begin
            return (col < `VID_H_ACTIVE / 2) ? p1 : p2;
        end
        return p1;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        errors++;
        $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("pixels checked %0d, tick intervals checked %0d, errors %0d",
            pixels_checked, ticks_checked, errors);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        cfg.we = 1'b1;
        cfg.addr = addr;
        cfg.data = data;
        @(posedge clk);
        #1;
        cfg.we = 1'b0;
    endtask

    task automatic push_line(input int row, input logic skip2);
        for (int col = 0; col < `VID_H_ACTIVE; col++) begin
            cam1 = {1'b1, cam_pixel(cur_base1, row, col)};
            cam2 = {!skip2, cam_pixel(cur_base2, row, col)};
            @(posedge clk);
            #1;
        end
        cam1.valid = 1'b0;
        cam2.valid = 1'b0;
    endtask

    task automatic wait_de_fall();
        logic seen;
        logic done;
        seen = 1'b0;
        done = 1'b0;
        for (int n = 0; n < TIMEOUT && !done; n++) begin
            @(posedge clk);
            #1;
            if (hdmi_de) begin
                seen = 1'b1;
            end else if (seen) begin
                done = 1'b1;
            end
        end
        if (!done) begin
            abort_run("Timeout while waiting for de to fall");
        end
    endtask

    task automatic wait_vsync_rise();
        int start;
        logic done;
        start = vs_rises;
        done = 1'b0;
        for (int n = 0; n < TIMEOUT && !done; n++) begin
            @(posedge clk);
            #1;
            done = (vs_rises != start);
        end
        if (!done) begin
            abort_run("Timeout while waiting for vsync to rise");
        end
    endtask

    // monitor samples half a cycle after the outputs change.
    always @(negedge clk) begin
        if (rst) begin
            if (hdmi_de || hdmi_hsync || hdmi_vsync || buf_tick || comb_err) begin
                errors++;
                $display("An output was active during reset at %0t", $time);
            end
            if ({hdmi_r, hdmi_g, hdmi_b} !== 24'h0) begin
                report_mismatch("rgb", {hdmi_r, hdmi_g, hdmi_b}, 0);
            end
        end else begin
            if (buf_tick) begin
                tick_cnt++;
            end
            if (hdmi_hsync) begin
                hs_run++;
            end else if (hs_run != 0) begin
                if (hs_run != `VID_H_SYNC) begin
                    report_mismatch("hsync run", hs_run, `VID_H_SYNC);
                end
                hs_run = 0;
            end
            if (hdmi_vsync) begin
                vs_run++;
            end else if (vs_run != 0) begin
                if (vs_run != `VID_V_SYNC * LINE_TOTAL) begin
                    report_mismatch("vsync run", vs_run, `VID_V_SYNC * LINE_TOTAL);
                end
                vs_run = 0;
            end
            if (hdmi_de && checking) begin
                exp_pix = (y == blank_line) ? '0 : expected_pixel(x, y);
                pixels_checked++;
                if (hdmi_r !== {exp_pix[15:11], 3'b000}) begin
                    report_mismatch("hdmi_r", hdmi_r, {exp_pix[15:11], 3'b000});
                end
                if (hdmi_g !== {exp_pix[10:5], 2'b00}) begin
                    report_mismatch("hdmi_g", hdmi_g, {exp_pix[10:5], 2'b00});
                end
                if (hdmi_b !== {exp_pix[4:0], 3'b000}) begin
                    report_mismatch("hdmi_b", hdmi_b, {exp_pix[4:0], 3'b000});
                end
                if ((blank_line < 0 || y < blank_line) && comb_err !== 1'b0) begin
                    report_mismatch("comb_err", comb_err, 0);
                end
            end
            if (hdmi_de) begin
                x++;
            end else if (de_prev) begin
                if (x != `VID_H_ACTIVE) begin
                    report_mismatch("de per line", x, `VID_H_ACTIVE);
                end
                x = 0;
                y++;
            end
            if (hdmi_vsync && !vs_prev) begin
                vs_rises++;
                if (y != `VID_V_ACTIVE) begin
                    report_mismatch("de lines", y, `VID_V_ACTIVE);
                end
                y = 0;
                if (tick_armed) begin
                    ticks_checked++;
                    if (tick_cnt != ((((vs_rises - tick_ref) % ((cur_div == 0) ? 1 : cur_div))
                            == 0) ? 1 : 0)) begin
                        report_mismatch("buf_tick count", tick_cnt,
                            (((vs_rises - tick_ref) % ((cur_div == 0) ? 1 : cur_div)) == 0));
                    end
                end
                tick_cnt = 0;
            end
        end
        de_prev = hdmi_de;
        vs_prev = hdmi_vsync;
    end

    initial begin
        rst = 1'b1;
        cam1 = '0;
        cam2 = '0;
        cfg = '0;
        errors = 0;
        pixels_checked = 0;
        ticks_checked = 0;
        x = 0;
        y = 0;
        hs_run = 0;
        vs_run = 0;
        vs_rises = 0;
        tick_cnt = 0;
        de_prev = 1'b0;
        vs_prev = 1'b0;
        checking = 1'b0;
        tick_armed = 1'b0;
        tick_ref = 0;
        blank_line = -1;
        cur_mode = 2'd0;
        cur_div = '0;
        cur_base1 = '0;
        cur_base2 = '0;
        lcg_state = 32'h464b03d4;

        // mode 3 and divider 0 cover the fallback rules.
        tbl_mode = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd1};
        tbl_div = '{16'd1, 16'd2, 16'd3, 16'd0, 16'd2};
        tbl_starve = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
        for (int r = 0; r < NUM_ROWS; r++) begin
            lcg_state = lcg_next(lcg_state);
            tbl_base1[r] = lcg_state[31:16];
            lcg_state = lcg_next(lcg_state);
            tbl_base2[r] = lcg_state[31:16];
        end

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // first frame underflows since nothing is queued yet.
        wait_vsync_rise();
        for (int r = 0; r < NUM_ROWS; r++) begin
            write_reg(REG_MODE, reg_data_t'(tbl_mode[r]));
            write_reg(REG_TICK_DIV, tbl_div[r]);
            tick_ref = vs_rises;
            cur_div = tbl_div[r];
            tick_armed = 1'b1;
            write_reg(REG_ERR_CLR, '0);
            cur_mode = tbl_mode[r];
            cur_base1 = tbl_base1[r];
            cur_base2 = tbl_base2[r];
            checking = 1'b1;
            for (int f = 0; f < FRAMES_PER_ROW; f++) begin
                blank_line = (tbl_starve[r] && f == FRAMES_PER_ROW - 1) ?
                    `VID_V_ACTIVE - 1 : -1;
                push_line(0, 1'b0);
                for (int row = 1; row < `VID_V_ACTIVE; row++) begin
                    wait_de_fall();
                    push_line(row, row == blank_line);
                end
                wait_vsync_rise();
            end
        end

        // starved line leaves the flag set until cleared.
        if (comb_err !== 1'b1) begin
            report_mismatch("comb_err", comb_err, 1);
        end
        write_reg(REG_ERR_CLR, '0);
        @(posedge clk);
        #1;
        if (comb_err !== 1'b0) begin
            report_mismatch("comb_err", comb_err, 0);
        end
        checking = 1'b0;
        if (pixels_checked != NUM_ROWS * FRAMES_PER_ROW * `VID_V_ACTIVE * `VID_H_ACTIVE) begin
            errors++;
            $display("The count of displayed pixels differs from the count fed");
        end

        $display("pixels checked %0d, tick intervals checked %0d, errors %0d",
            pixels_checked, ticks_checked, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : tb_video_top

`default_nettype wire

//--- files.f
+incdir+hdl
hdl/video_pkg.sv
hdl/line_fifo.sv
hdl/pixel_combine.sv
hdl/sync_gen.sv
hdl/video_regs.sv
hdl/video_top.sv
testbench/tb_video_top.sv

//--- Bender.yml
package:
  name: video_top

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/video_pkg.sv
      - hdl/line_fifo.sv
      - hdl/pixel_combine.sv
      - hdl/sync_gen.sv
      - hdl/video_regs.sv
      - hdl/video_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - testbench/tb_video_top.sv
